// File: Bender.yml
package:
  name: wb_top

sources:
  - hw/wb_types_pkg.sv
  - hw/mem_wb.sv
  - hw/writeback_unit.sv
  - hw/register_file.sv
  - hw/wb_top.sv
  - target: test
    files:
      - tests/wb_top_sva.sv
      - tests/wb_top_tb.sv

// File: files.f
hw/wb_types_pkg.sv
hw/mem_wb.sv
hw/writeback_unit.sv
hw/register_file.sv
hw/wb_top.sv
tests/wb_top_sva.sv
tests/wb_top_tb.sv

// File: hw/mem_wb.sv
`timescale 1ns/10ps

module mem_wb (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 wb_en,
  // fields from the memory stage.
  input  wb_types_pkg::word_t    jump_addr,
  input  wb_types_pkg::word_t    branch_addr,
  input  wb_types_pkg::word_t    jr_addr,
  input  wb_types_pkg::word_t    npc,
  input  wb_types_pkg::word_t    lui_value,
  input  wb_types_pkg::word_t    alu_result,
  input  wb_types_pkg::word_t    dmem_load,
  input  wb_types_pkg::word_t    instr,
  input  wb_types_pkg::pcsrc_t   pc_src,
  input  wb_types_pkg::wsrc_t    w_src,
  input  logic                   wen,
  input  wb_types_pkg::regbits_t wsel,
  // latched fields.
  output wb_types_pkg::word_t    jump_addr_q,
  output wb_types_pkg::word_t    branch_addr_q,
  output wb_types_pkg::word_t    jr_addr_q,
  output wb_types_pkg::word_t    npc_q,
  output wb_types_pkg::word_t    lui_value_q,
  output wb_types_pkg::word_t    alu_result_q,
  output wb_types_pkg::word_t    dmem_load_q,
  output wb_types_pkg::word_t    instr_q,
  output wb_types_pkg::pcsrc_t   pc_src_q,
  output wb_types_pkg::wsrc_t    w_src_q,
  output logic                   wen_q,
  output wb_types_pkg::regbits_t wsel_q
);

  import wb_types_pkg::*;

  // ----------------------------------------------------------------------
  // pipeline register.
  // ----------------------------------------------------------------------
  // everything loads together; a low wb_en holds the stage.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      jump_addr_q   <= '0;
      branch_addr_q <= '0;
      jr_addr_q     <= '0;
      npc_q         <= '0;
      lui_value_q   <= '0;
      alu_result_q  <= '0;
      dmem_load_q   <= '0;
      instr_q       <= '0;
      pc_src_q      <= ADD4;
      w_src_q       <= LUI;
      wen_q         <= 1'b0;
      wsel_q        <= '0;
    end else if (wb_en) begin
      jump_addr_q   <= jump_addr;
      branch_addr_q <= branch_addr;
      jr_addr_q     <= jr_addr;
      npc_q         <= npc;
      lui_value_q   <= lui_value;
      alu_result_q  <= alu_result;
      dmem_load_q   <= dmem_load;
      instr_q       <= instr;
      pc_src_q      <= pc_src;
      w_src_q       <= w_src;
      wen_q         <= wen;
      wsel_q        <= wsel;
    end
  end

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   wen,
  input  wb_types_pkg::regbits_t wsel,
  input  wb_types_pkg::word_t    wdat,
  input  wb_types_pkg::regbits_t rsel1,
  input  wb_types_pkg::regbits_t rsel2,
  output wb_types_pkg::word_t    rdat1,
  output wb_types_pkg::word_t    rdat2
);

  import wb_types_pkg::*;

  word_t    regs [REG_COUNT];
  regbits_t rd_sel [2];
  word_t    rd_dat [2];

  // ----------------------------------------------------------------------
  // write port.
  // ----------------------------------------------------------------------
  // register zero is never written.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  // ----------------------------------------------------------------------
  // read ports.
  // ----------------------------------------------------------------------
  assign rd_sel[0] = rsel1;
  assign rd_sel[1] = rsel2;

  for (genvar p = 0; p < 2; p++) begin : g_read
    // pending write to the same index wins over the stored word.
    always_comb begin
      if (rd_sel[p] == '0) begin
        rd_dat[p] = '0;
      end else if (wen && (wsel == rd_sel[p])) begin
        rd_dat[p] = wdat;
      end else begin
        rd_dat[p] = regs[rd_sel[p]];
      end
    end
  end

  assign rdat1 = rd_dat[0];
  assign rdat2 = rd_dat[1];

endmodule

// File: hw/wb_top.sv
`timescale 1ns/10ps

module wb_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   wb_en,
  // memory stage fields.
  input  wb_types_pkg::word_t    jump_addr,
  input  wb_types_pkg::word_t    branch_addr,
  input  wb_types_pkg::word_t    jr_addr,
  input  wb_types_pkg::word_t    npc,
  input  wb_types_pkg::word_t    lui_value,
  input  wb_types_pkg::word_t    alu_result,
  input  wb_types_pkg::word_t    dmem_load,
  input  wb_types_pkg::word_t    instr,
  input  wb_types_pkg::pcsrc_t   pc_src,
  input  wb_types_pkg::wsrc_t    w_src,
  input  logic                   wen,
  input  wb_types_pkg::regbits_t wsel,
  // register read ports.
  input  wb_types_pkg::regbits_t rsel1,
  input  wb_types_pkg::regbits_t rsel2,
  output wb_types_pkg::word_t    rdat1,
  output wb_types_pkg::word_t    rdat2,
  output wb_types_pkg::word_t    next_pc,
  output logic                   halt
);

  import wb_types_pkg::*;

  // ----------------------------------------------------------------------
  // latched stage fields.
  // ----------------------------------------------------------------------
  word_t    jump_addr_q;
  word_t    branch_addr_q;
  word_t    jr_addr_q;
  word_t    npc_q;
  word_t    lui_value_q;
  word_t    alu_result_q;
  word_t    dmem_load_q;
  word_t    instr_q;
  pcsrc_t   pc_src_q;
  wsrc_t    w_src_q;
  logic     wen_q;
  regbits_t wsel_q;

  // register file write side.
  word_t    wb_wdat;
  logic     wb_wen;
  regbits_t wb_wsel;

  mem_wb mem_wb_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .wb_en         (wb_en),
    .jump_addr     (jump_addr),
    .branch_addr   (branch_addr),
    .jr_addr       (jr_addr),
    .npc           (npc),
    .lui_value     (lui_value),
    .alu_result    (alu_result),
    .dmem_load     (dmem_load),
    .instr         (instr),
    .pc_src        (pc_src),
    .w_src         (w_src),
    .wen           (wen),
    .wsel          (wsel),
    .jump_addr_q   (jump_addr_q),
    .branch_addr_q (branch_addr_q),
    .jr_addr_q     (jr_addr_q),
    .npc_q         (npc_q),
    .lui_value_q   (lui_value_q),
    .alu_result_q  (alu_result_q),
    .dmem_load_q   (dmem_load_q),
    .instr_q       (instr_q),
    .pc_src_q      (pc_src_q),
    .w_src_q       (w_src_q),
    .wen_q         (wen_q),
    .wsel_q        (wsel_q)
  );

  writeback_unit writeback_unit_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .jump_addr_q   (jump_addr_q),
    .branch_addr_q (branch_addr_q),
    .jr_addr_q     (jr_addr_q),
    .npc_q         (npc_q),
    .lui_value_q   (lui_value_q),
    .alu_result_q  (alu_result_q),
    .dmem_load_q   (dmem_load_q),
    .instr_q       (instr_q),
    .pc_src_q      (pc_src_q),
    .w_src_q       (w_src_q),
    .wen_q         (wen_q),
    .wsel_q        (wsel_q),
    .wdat          (wb_wdat),
    .reg_wen       (wb_wen),
    .wsel_out      (wb_wsel),
    .next_pc       (next_pc),
    .halt          (halt)
  );

  register_file register_file_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wb_wen),
    .wsel  (wb_wsel),
    .wdat  (wb_wdat),
    .rsel1 (rsel1),
    .rsel2 (rsel2),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

endmodule

// File: hw/wb_types_pkg.sv
package wb_types_pkg;

  // ----------------------------------------------------------------------
  // sizes.
  // ----------------------------------------------------------------------
  localparam int WORD_W     = 32;
  localparam int REG_COUNT  = 32;
  localparam int REG_ADDR_W = $clog2(REG_COUNT);

  // opcode sits in the top bits of the instruction word.
  localparam int OP_W   = 6;
  localparam int OP_LSB = WORD_W - OP_W;

  // all ones marks a halt.
  localparam logic [OP_W-1:0] HALT_OP = 6'b111111;

  // ----------------------------------------------------------------------
  // types.
  // ----------------------------------------------------------------------
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] regbits_t;

  // next pc source.
  typedef enum logic [1:0] {
    ADD4   = 2'd0,
    BRANCH = 2'd1,
    JUMP   = 2'd2,
    JR     = 2'd3
  } pcsrc_t;

  // writeback value source.
  typedef enum logic [1:0] {
    LUI  = 2'd0,
    ALU  = 2'd1,
    DMEM = 2'd2,
    LINK = 2'd3
  } wsrc_t;

endpackage

// File: hw/writeback_unit.sv
`timescale 1ns/10ps

module writeback_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  wb_types_pkg::word_t    jump_addr_q,
  input  wb_types_pkg::word_t    branch_addr_q,
  input  wb_types_pkg::word_t    jr_addr_q,
  input  wb_types_pkg::word_t    npc_q,
  input  wb_types_pkg::word_t    lui_value_q,
  input  wb_types_pkg::word_t    alu_result_q,
  input  wb_types_pkg::word_t    dmem_load_q,
  input  wb_types_pkg::word_t    instr_q,
  input  wb_types_pkg::pcsrc_t   pc_src_q,
  input  wb_types_pkg::wsrc_t    w_src_q,
  input  logic                   wen_q,
  input  wb_types_pkg::regbits_t wsel_q,
  output wb_types_pkg::word_t    wdat,
  output logic                   reg_wen,
  output wb_types_pkg::regbits_t wsel_out,
  output wb_types_pkg::word_t    next_pc,
  output logic                   halt
);

  import wb_types_pkg::*;

  // writeback value mux.
  always_comb begin
    unique case (w_src_q)
      LUI:     wdat = lui_value_q;
      ALU:     wdat = alu_result_q;
      DMEM:    wdat = dmem_load_q;
      LINK:    wdat = npc_q;
      default: wdat = lui_value_q;
    endcase
  end

  // next pc mux.
  always_comb begin
    unique case (pc_src_q)
      ADD4:    next_pc = npc_q;
      BRANCH:  next_pc = branch_addr_q;
      JUMP:    next_pc = jump_addr_q;
      JR:      next_pc = jr_addr_q;
      default: next_pc = npc_q;
    endcase
  end

  assign reg_wen  = wen_q;
  assign wsel_out = wsel_q;

  // sticky until reset.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (instr_q[WORD_W-1:OP_LSB] == HALT_OP) begin
      halt <= 1'b1;
    end
  end

endmodule

// File: tests/wb_top_sva.sv
`timescale 1ns/10ps

module wb_top_sva (
  input logic                   CLK,
  input logic                   nRST,
  input wb_types_pkg::word_t    next_pc,
  input logic                   halt,
  input wb_types_pkg::regbits_t rsel1,
  input wb_types_pkg::word_t    rdat1
);

  import wb_types_pkg::*;

  // count of failed assertions.
  int unsigned fail_count = 0;

  // ----------------------------------------------------------------------
  // reset state.
  // ----------------------------------------------------------------------
  a_pc_in_reset : assert property (
    @(posedge CLK) !nRST |-> (next_pc == '0)
  ) else begin
    $error("next_pc not zero while in reset");
    fail_count++;
  end

  // ----------------------------------------------------------------------
  // halt and register zero.
  // ----------------------------------------------------------------------
  // only reset may clear the flag.
  a_halt_sticky : assert property (
    @(posedge CLK) disable iff (!nRST) $past(halt) |-> halt
  ) else begin
    $error("halt dropped without a reset");
    fail_count++;
  end

  a_r0_reads_zero : assert property (
    @(posedge CLK) (rsel1 == '0) |-> (rdat1 == '0)
  ) else begin
    $error("register zero read back nonzero");
    fail_count++;
  end

endmodule

// File: tests/wb_top_tb.sv
`timescale 1ns/10ps

module wb_top_tb;

  import wb_types_pkg::*;

  // the tests take a bit over 110 cycles.
  localparam int TIMEOUT_CYCLES = 400;

  logic     CLK;
  logic     nRST;
  logic     wb_en;
  word_t    jump_addr;
  word_t    branch_addr;
  word_t    jr_addr;
  word_t    npc;
  word_t    lui_value;
  word_t    alu_result;
  word_t    dmem_load;
  word_t    instr;
  pcsrc_t   pc_src;
  wsrc_t    w_src;
  logic     wen;
  regbits_t wsel;
  regbits_t rsel1;
  regbits_t rsel2;
  word_t    rdat1;
  word_t    rdat2;
  word_t    next_pc;
  logic     halt;

  integer seed = 76;
  int     cycle_count = 0;

  // expected register contents.
  word_t  model [REG_COUNT];

  wb_top wb_top_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .wb_en       (wb_en),
    .jump_addr   (jump_addr),
    .branch_addr (branch_addr),
    .jr_addr     (jr_addr),
    .npc         (npc),
    .lui_value   (lui_value),
    .alu_result  (alu_result),
    .dmem_load   (dmem_load),
    .instr       (instr),
    .pc_src      (pc_src),
    .w_src       (w_src),
    .wen         (wen),
    .wsel        (wsel),
    .rsel1       (rsel1),
    .rsel2       (rsel2),
    .rdat1       (rdat1),
    .rdat2       (rdat2),
    .next_pc     (next_pc),
    .halt        (halt)
  );

  bind wb_top wb_top_sva wb_top_sva_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .next_pc (next_pc),
    .halt    (halt),
    .rsel1   (rsel1),
    .rdat1   (rdat1)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error("Timeout: the tests did not finish within the cycle limit.");
    end
  end

  // bound checker failures.
  always @(negedge CLK) begin
    if (wb_top_i.wb_top_sva_i.fail_count != 0) begin
      stop_on_error("An assertion in the bound checker failed.");
    end
  end

  // ----------------------------------------------------------------------
  // checks.
  // ----------------------------------------------------------------------
  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pc(word_t got, word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: next_pc = %h, expected %h", $time, got, exp));
    end
  endtask

  // reads through port 1 right after a falling edge.
  task automatic check_reg(regbits_t idx, word_t exp);
    rsel1 = idx;
    #1;
    check_word($sformatf("rdat1 (r%0d)", idx), rdat1, exp);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < REG_COUNT; i++) begin
      @(negedge CLK);
      check_reg(regbits_t'(i), model[i]);
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus helpers.
  // ----------------------------------------------------------------------
  function automatic regbits_t pick_reg();
    regbits_t idx;
    idx = regbits_t'($random(seed));
    if (idx == '0) begin
      idx = 5'd1;
    end
    return idx;
  endfunction

  // random field set; the opcode stays clear so it is never a halt.
  task automatic drive_fields(pcsrc_t ps, wsrc_t ws, logic we, regbits_t idx);
    jump_addr   = $random(seed);
    branch_addr = $random(seed);
    jr_addr     = $random(seed);
    npc         = $random(seed);
    lui_value   = $random(seed);
    alu_result  = $random(seed);
    dmem_load   = $random(seed);
    instr       = $random(seed);
    instr[WORD_W-1:OP_LSB] = '0;
    pc_src      = ps;
    w_src       = ws;
    wen         = we;
    wsel        = idx;
  endtask

  function automatic word_t expected_wdat();
    case (w_src)
      ALU:     return alu_result;
      DMEM:    return dmem_load;
      LINK:    return npc;
      default: return lui_value;
    endcase
  endfunction

  function automatic word_t expected_pc();
    case (pc_src)
      BRANCH:  return branch_addr;
      JUMP:    return jump_addr;
      JR:      return jr_addr;
      default: return npc;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // tests.
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    check_pc(next_pc, '0);
    check_bit("halt", halt, 1'b0);
    check_all_regs();
  endtask

  task automatic test_wdat_select();
    word_t    exp;
    regbits_t idx;
    for (int k = 0; k < 4; k++) begin
      @(negedge CLK);
      idx = pick_reg();
      drive_fields(ADD4, wsrc_t'(k), 1'b1, idx);
      exp = expected_wdat();
      @(negedge CLK);
      wen = 1'b0;
      // write still pending so both ports forward it.
      check_reg(idx, exp);
      rsel2 = idx;
      #1;
      check_word("rdat2", rdat2, exp);
      @(negedge CLK);
      model[idx] = exp;
      check_reg(idx, exp);
    end
  endtask

  task automatic test_pc_select();
    word_t exp;
    for (int k = 0; k < 4; k++) begin
      @(negedge CLK);
      drive_fields(pcsrc_t'(k), ALU, 1'b0, '0);
      exp = expected_pc();
      @(negedge CLK);
      check_pc(next_pc, exp);
    end
  endtask

  task automatic test_hold_stage();
    word_t    pc_a;
    word_t    dat_a;
    word_t    pc_b;
    word_t    dat_b;
    regbits_t idx_a;
    regbits_t idx_b;
    @(negedge CLK);
    idx_a = pick_reg();
    idx_b = (idx_a == 5'd31) ? 5'd1 : idx_a + 5'd1;
    drive_fields(JUMP, ALU, 1'b1, idx_a);
    pc_a  = expected_pc();
    dat_a = expected_wdat();
    // stall with fresh fields on the inputs each cycle.
    repeat (4) begin
      @(negedge CLK);
      wb_en = 1'b0;
      drive_fields(BRANCH, DMEM, 1'b1, idx_b);
      pc_b  = expected_pc();
      dat_b = expected_wdat();
      check_pc(next_pc, pc_a);
    end
    model[idx_a] = dat_a;
    check_reg(idx_a, dat_a);
    check_reg(idx_b, model[idx_b]);
    @(negedge CLK);
    wb_en = 1'b1;
    @(negedge CLK);
    wen = 1'b0;
    check_pc(next_pc, pc_b);
    check_reg(idx_b, dat_b);
    @(negedge CLK);
    model[idx_b] = dat_b;
    check_reg(idx_b, dat_b);
  endtask

  task automatic test_reg_zero();
    @(negedge CLK);
    drive_fields(ADD4, ALU, 1'b1, '0);
    @(negedge CLK);
    drive_fields(ADD4, LINK, 1'b0, pick_reg());
    check_reg('0, '0);
    @(negedge CLK);
    check_reg('0, '0);
    check_all_regs();
  endtask

  task automatic test_halt();
    @(negedge CLK);
    drive_fields(ADD4, ALU, 1'b0, '0);
    instr[WORD_W-1:OP_LSB] = HALT_OP;
    check_bit("halt", halt, 1'b0);
    @(negedge CLK);
    drive_fields(ADD4, ALU, 1'b0, '0);
    // latched now and the flag follows at the next edge.
    check_bit("halt", halt, 1'b0);
    @(negedge CLK);
    check_bit("halt", halt, 1'b1);
    repeat (4) begin
      @(negedge CLK);
      drive_fields(pcsrc_t'($random(seed)), ALU, 1'b0, '0);
      check_bit("halt", halt, 1'b1);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence.
  // ----------------------------------------------------------------------
  initial begin
    nRST        = 1'b0;
    wb_en       = 1'b1;
    jump_addr   = '0;
    branch_addr = '0;
    jr_addr     = '0;
    npc         = '0;
    lui_value   = '0;
    alu_result  = '0;
    dmem_load   = '0;
    instr       = '0;
    pc_src      = ADD4;
    w_src       = LUI;
    wen         = 1'b0;
    wsel        = '0;
    rsel1       = '0;
    rsel2       = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (10) @(negedge CLK);
    check_pc(next_pc, '0);
    nRST = 1'b1;

    test_reset_state();
    test_wdat_select();
    test_pc_select();
    test_hold_stage();
    test_reg_zero();
    test_halt();

    if (wb_top_i.wb_top_sva_i.fail_count != 0) begin
      stop_on_error("An assertion in the bound checker failed.");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
